/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rvc_decoder
FILELIST ?= rvc_decoder.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* design/rvc_credit_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_credit_queue #(
	parameter int DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic wr_valid_i,
	input  rvc_pkg::rvc_result_t wr_data_i,
	output logic in_credit_o,
	output logic out_valid_o,
	output rvc_pkg::rvc_result_t out_data_o,
	input  logic out_credit_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	rvc_pkg::rvc_result_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// head leaves whenever something is queued and downstream has room
	assign pop = (count != '0) && (credits != '0);
	assign out_valid_o = pop;
	assign in_credit_o = pop;
	assign out_data_o = mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(OUT_CREDITS);
		end else begin
			if (wr_valid_i) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_valid_i, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// spend on pop, refill on returned credit
			case ({pop, out_credit_i})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

	// producer must stay within the credits handed back upstream
	a_no_write_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wr_valid_i |-> (count != CNT_W'(DEPTH)))
		else $error("write while queue full");

	// consumer never returns more than it was given
	a_credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		credits <= CRD_W'(OUT_CREDITS))
		else $error("downstream credit counter above limit");

	// last credit spent, output stalls until one comes back
	a_stall_on_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(out_valid_o && (credits == CRD_W'(1)) && !out_credit_i) |=> !out_valid_o)
		else $error("output valid with no downstream credit");

endmodule

`default_nettype wire

/* design/rvc_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_decoder #(
	parameter int DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic clk_i,
	input  logic arst_n_i,

	// upstream, credit based
	input  logic in_valid_i,
	input  logic [rvc_pkg::INSTR_W-1:0] in_instr_i,
	output logic in_credit_o,

	// downstream, credit based
	output logic out_valid_o,
	output rvc_pkg::rvc_result_t out_result_o,
	input  logic out_credit_i
);

	rvc_pkg::rvc_result_t exp_result;

	rvc_expander u_expander (
		.instr_i (in_instr_i),
		.result_o(exp_result)
	);

	rvc_credit_queue #(
		.DEPTH      (DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_queue (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.wr_valid_i  (in_valid_i),
		.wr_data_i   (exp_result),
		.in_credit_o (in_credit_o),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_result_o),
		.out_credit_i(out_credit_i)
	);

endmodule

`default_nettype wire

/* design/rvc_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
	input  logic [rvc_pkg::INSTR_W-1:0] instr_i,
	output rvc_pkg::rvc_result_t result_o
);

	rvc_pkg::rvc_half_u half;
	rvc_pkg::quad_out_t q0_out;
	rvc_pkg::quad_out_t q1_out;
	rvc_pkg::quad_out_t q2_out;
	rvc_pkg::quad_out_t sel;

	assign half = instr_i[rvc_pkg::HALF_W-1:0];

	rvc_quadrant0 u_quadrant0 (
		.half_i(half),
		.out_o (q0_out)
	);

	rvc_quadrant1 u_quadrant1 (
		.half_i(half),
		.out_o (q1_out)
	);

	rvc_quadrant2 u_quadrant2 (
		.half_i(half),
		.out_o (q2_out)
	);

	always_comb begin
		case (instr_i[1:0])
			rvc_pkg::QUAD0: sel = q0_out;
			rvc_pkg::QUAD1: sel = q1_out;
			rvc_pkg::QUAD2: sel = q2_out;
			// full-width word, nothing to expand
			default: sel = '{instr: instr_i, illegal: 1'b0};
		endcase
	end

	// an illegal halfword keeps the whole fetch word, upper half included
	assign result_o = '{
		instr: sel.illegal ? instr_i : sel.instr,
		is_compressed: (instr_i[1:0] != rvc_pkg::QUAD_FULL),
		illegal: sel.illegal
	};

endmodule

`default_nettype wire

/* design/rvc_pkg.sv */
`default_nettype none

package rvc_pkg;

	localparam int INSTR_W = 32;
	localparam int HALF_W = 16;

	// base ISA major opcodes
	localparam logic [6:0] OPCODE_LOAD = 7'h03;
	localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
	localparam logic [6:0] OPCODE_STORE = 7'h23;
	localparam logic [6:0] OPCODE_OP = 7'h33;
	localparam logic [6:0] OPCODE_LUI = 7'h37;
	localparam logic [6:0] OPCODE_BRANCH = 7'h63;
	localparam logic [6:0] OPCODE_JALR = 7'h67;
	localparam logic [6:0] OPCODE_JAL = 7'h6f;

	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_RA = 5'd1;
	localparam logic [4:0] REG_SP = 5'd2;

	localparam logic [INSTR_W-1:0] EBREAK_INSTR = 32'h0010_0073;

	// low two bits of a fetch word
	localparam logic [1:0] QUAD0 = 2'b00;
	localparam logic [1:0] QUAD1 = 2'b01;
	localparam logic [1:0] QUAD2 = 2'b10;
	localparam logic [1:0] QUAD_FULL = 2'b11;

	typedef struct packed {
		logic [2:0] funct3;
		logic imm_hi;
		logic [4:0] rd;
		logic [4:0] imm_lo;
		logic [1:0] quad;
	} rvc_ci_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [7:0] imm;
		logic [2:0] rd_p;
		logic [1:0] quad;
	} rvc_ciw_t;

	// also covers CS and the register fields of CA
	typedef struct packed {
		logic [2:0] funct3;
		logic [2:0] imm_hi;
		logic [2:0] rs1_p;
		logic [1:0] imm_lo;
		logic [2:0] rd_p;
		logic [1:0] quad;
	} rvc_cl_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic off_hi;
		logic [1:0] funct2;
		logic [2:0] rs1_p;
		logic [4:0] off_lo;
		logic [1:0] quad;
	} rvc_cb_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [10:0] target;
		logic [1:0] quad;
	} rvc_cj_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [5:0] imm;
		logic [4:0] rs2;
		logic [1:0] quad;
	} rvc_css_t;

	typedef union packed {
		logic [HALF_W-1:0] raw;
		rvc_ci_t ci;
		rvc_ciw_t ciw;
		rvc_cl_t cl;
		rvc_cb_t cb;
		rvc_cj_t cj;
		rvc_css_t css;
	} rvc_half_u;

	typedef struct packed {
		logic [INSTR_W-1:0] instr;
		logic is_compressed;
		logic illegal;
	} rvc_result_t;

	typedef struct packed {
		logic [INSTR_W-1:0] instr;
		logic illegal;
	} quad_out_t;

endpackage

`default_nettype wire

/* design/rvc_quadrant0.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant0 (
	input  rvc_pkg::rvc_half_u half_i,
	output rvc_pkg::quad_out_t out_o
);

	rvc_pkg::rvc_ciw_t ciw;
	rvc_pkg::rvc_cl_t cl;
	logic [rvc_pkg::INSTR_W-1:0] instr;
	logic illegal;

	assign ciw = half_i.ciw;
	assign cl = half_i.cl;

	// 3-bit register fields select x8..x15
	always_comb begin
		instr = '0;
		illegal = 1'b0;
		case (ciw.funct3)
			3'b000: begin
				// c.addi4spn, immediate scaled by 4
				instr = {2'b00, ciw.imm[5:2], ciw.imm[7:6], ciw.imm[0], ciw.imm[1], 2'b00,
					rvc_pkg::REG_SP, 3'b000, 2'b01, ciw.rd_p, rvc_pkg::OPCODE_OP_IMM};
				illegal = (ciw.imm == 8'h00);
			end
			3'b010: begin
				instr = {5'b00000, cl.imm_lo[0], cl.imm_hi, cl.imm_lo[1], 2'b00,
					2'b01, cl.rs1_p, 3'b010, 2'b01, cl.rd_p, rvc_pkg::OPCODE_LOAD};
			end
			3'b110: begin
				instr = {5'b00000, cl.imm_lo[0], cl.imm_hi[2], 2'b01, cl.rd_p,
					2'b01, cl.rs1_p, 3'b010, cl.imm_hi[1:0], cl.imm_lo[1], 2'b00,
					rvc_pkg::OPCODE_STORE};
			end
			default: illegal = 1'b1;
		endcase
	end

	assign out_o = '{
		instr: illegal ? {{(rvc_pkg::INSTR_W - rvc_pkg::HALF_W){1'b0}}, half_i.raw} : instr,
		illegal: illegal
	};

endmodule

`default_nettype wire

/* design/rvc_quadrant1.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant1 (
	input  rvc_pkg::rvc_half_u half_i,
	output rvc_pkg::quad_out_t out_o
);

	rvc_pkg::rvc_ci_t ci;
	rvc_pkg::rvc_cl_t cl;
	rvc_pkg::rvc_cb_t cb;
	rvc_pkg::rvc_cj_t cj;
	logic [rvc_pkg::INSTR_W-1:0] instr;
	logic illegal;
	logic [2:0] alu_f3;
	logic alu_sub;

	assign ci = half_i.ci;
	assign cl = half_i.cl;
	assign cb = half_i.cb;
	assign cj = half_i.cj;

	always_comb begin
		instr = '0;
		illegal = 1'b0;
		alu_f3 = 3'b000;
		alu_sub = 1'b0;
		case (ci.funct3)
			3'b000: begin
				// c.addi, c.nop when rd is x0
				instr = {{7{ci.imm_hi}}, ci.imm_lo, ci.rd, 3'b000, ci.rd,
					rvc_pkg::OPCODE_OP_IMM};
			end
			3'b001, 3'b101: begin
				// c.jal links to ra, c.j does not link
				instr = {cj.target[10], cj.target[6], cj.target[8:7], cj.target[4],
					cj.target[5], cj.target[0], cj.target[9], cj.target[3:1],
					{9{cj.target[10]}},
					(cj.funct3[2] ? rvc_pkg::REG_ZERO : rvc_pkg::REG_RA),
					rvc_pkg::OPCODE_JAL};
			end
			3'b010: begin
				instr = {{7{ci.imm_hi}}, ci.imm_lo, rvc_pkg::REG_ZERO, 3'b000, ci.rd,
					rvc_pkg::OPCODE_OP_IMM};
			end
			3'b011: begin
				if (ci.rd == rvc_pkg::REG_SP) begin
					// c.addi16sp, immediate scaled by 16
					instr = {{3{ci.imm_hi}}, ci.imm_lo[2:1], ci.imm_lo[3], ci.imm_lo[0],
						ci.imm_lo[4], 4'b0000, rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
						rvc_pkg::OPCODE_OP_IMM};
				end else begin
					instr = {{15{ci.imm_hi}}, ci.imm_lo, ci.rd, rvc_pkg::OPCODE_LUI};
				end
				illegal = ({ci.imm_hi, ci.imm_lo} == 6'd0);
			end
			3'b100: begin
				case (cb.funct2)
					2'b00, 2'b01: begin
						// srli / srai, funct2[0] picks arithmetic
						instr = {1'b0, cb.funct2[0], 5'b00000, cb.off_lo, 2'b01, cb.rs1_p,
							3'b101, 2'b01, cb.rs1_p, rvc_pkg::OPCODE_OP_IMM};
						illegal = cb.off_hi;
					end
					2'b10: begin
						instr = {{7{cb.off_hi}}, cb.off_lo, 2'b01, cb.rs1_p, 3'b111,
							2'b01, cb.rs1_p, rvc_pkg::OPCODE_OP_IMM};
					end
					default: begin
						case ({cb.off_hi, cl.imm_lo})
							3'b000: alu_sub = 1'b1;
							3'b001: alu_f3 = 3'b100;
							3'b010: alu_f3 = 3'b110;
							3'b011: alu_f3 = 3'b111;
							default: illegal = 1'b1;
						endcase
						instr = {1'b0, alu_sub, 5'b00000, 2'b01, cl.rd_p, 2'b01, cb.rs1_p,
							alu_f3, 2'b01, cb.rs1_p, rvc_pkg::OPCODE_OP};
					end
				endcase
			end
			default: begin
				// c.beqz / c.bnez against x0
				instr = {{4{cb.off_hi}}, cb.off_lo[4:3], cb.off_lo[0], rvc_pkg::REG_ZERO,
					2'b01, cb.rs1_p, 2'b00, cb.funct3[0], cb.funct2, cb.off_lo[2:1],
					cb.off_hi, rvc_pkg::OPCODE_BRANCH};
			end
		endcase
	end

	assign out_o = '{
		instr: illegal ? {{(rvc_pkg::INSTR_W - rvc_pkg::HALF_W){1'b0}}, half_i.raw} : instr,
		illegal: illegal
	};

endmodule

`default_nettype wire

/* design/rvc_quadrant2.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_quadrant2 (
	input  rvc_pkg::rvc_half_u half_i,
	output rvc_pkg::quad_out_t out_o
);

	rvc_pkg::rvc_ci_t ci;
	rvc_pkg::rvc_css_t css;
	logic [rvc_pkg::INSTR_W-1:0] instr;
	logic illegal;

	assign ci = half_i.ci;
	assign css = half_i.css;

	always_comb begin
		instr = '0;
		illegal = 1'b0;
		case (ci.funct3)
			3'b000: begin
				instr = {7'b0000000, ci.imm_lo, ci.rd, 3'b001, ci.rd,
					rvc_pkg::OPCODE_OP_IMM};
				illegal = ci.imm_hi;
			end
			3'b010: begin
				// c.lwsp, offset scaled by 4 from sp
				instr = {4'b0000, ci.imm_lo[1:0], ci.imm_hi, ci.imm_lo[4:2], 2'b00,
					rvc_pkg::REG_SP, 3'b010, ci.rd, rvc_pkg::OPCODE_LOAD};
				illegal = (ci.rd == rvc_pkg::REG_ZERO);
			end
			3'b100: begin
				// bit 12 and rs2 split mv/jr/add/jalr/ebreak
				if (!ci.imm_hi) begin
					if (css.rs2 != rvc_pkg::REG_ZERO) begin
						instr = {7'b0000000, css.rs2, rvc_pkg::REG_ZERO, 3'b000, ci.rd,
							rvc_pkg::OPCODE_OP};
					end else begin
						instr = {12'h000, ci.rd, 3'b000, rvc_pkg::REG_ZERO,
							rvc_pkg::OPCODE_JALR};
						illegal = (ci.rd == rvc_pkg::REG_ZERO);
					end
				end else if (css.rs2 != rvc_pkg::REG_ZERO) begin
					instr = {7'b0000000, css.rs2, ci.rd, 3'b000, ci.rd, rvc_pkg::OPCODE_OP};
				end else if (ci.rd == rvc_pkg::REG_ZERO) begin
					instr = rvc_pkg::EBREAK_INSTR;
				end else begin
					instr = {12'h000, ci.rd, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPCODE_JALR};
				end
			end
			3'b110: begin
				instr = {4'b0000, css.imm[1:0], css.imm[5], css.rs2, rvc_pkg::REG_SP,
					3'b010, css.imm[4:2], 2'b00, rvc_pkg::OPCODE_STORE};
			end
			default: illegal = 1'b1;
		endcase
	end

	assign out_o = '{
		instr: illegal ? {{(rvc_pkg::INSTR_W - rvc_pkg::HALF_W){1'b0}}, half_i.raw} : instr,
		illegal: illegal
	};

endmodule

`default_nettype wire

/* rvc_decoder.f */
+incdir+include
design/rvc_pkg.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rvc_expander.sv
design/rvc_credit_queue.sv
design/rvc_decoder.sv
tb/tb_rvc_decoder.sv

/* include/rvc_tb_vectors.svh */
`ifndef RVC_TB_VECTORS_SVH
`define RVC_TB_VECTORS_SVH

// one row per fetch word with a name of up to 16 characters
typedef struct packed {
	logic [8*16-1:0] name;
	logic [rvc_pkg::INSTR_W-1:0] instr;
	logic [rvc_pkg::INSTR_W-1:0] exp_instr;
	logic exp_compressed;
	logic exp_illegal;
} rvc_vec_t;

localparam int RVC_NUM_VECTORS = 40;

localparam rvc_vec_t RVC_VECTORS [RVC_NUM_VECTORS] = '{
	'{"c.addi4spn", 32'h0000_0040, 32'h0041_0413, 1'b1, 1'b0},
	'{"c.addi4spn zero", 32'h0000_0004, 32'h0000_0004, 1'b1, 1'b1},
	'{"c.lw", 32'h0000_4144, 32'h0045_2483, 1'b1, 1'b0},
	'{"c.sw", 32'h0000_c504, 32'h0095_2423, 1'b1, 1'b0},
	'{"q0 funct3 001", 32'h0000_2000, 32'h0000_2000, 1'b1, 1'b1},
	'{"c.nop", 32'h0000_0001, 32'h0000_0013, 1'b1, 1'b0},
	'{"c.addi", 32'h0000_157d, 32'hfff5_0513, 1'b1, 1'b0},
	'{"c.jal", 32'h0000_2009, 32'h0020_00ef, 1'b1, 1'b0},
	'{"c.j", 32'h0000_bffd, 32'hffff_f06f, 1'b1, 1'b0},
	'{"c.li", 32'h0000_4595, 32'h0050_0593, 1'b1, 1'b0},
	'{"c.lui", 32'h0000_6605, 32'h0000_1637, 1'b1, 1'b0},
	'{"c.addi16sp", 32'h0000_6141, 32'h0101_0113, 1'b1, 1'b0},
	'{"c.lui zero", 32'h0000_6601, 32'h0000_6601, 1'b1, 1'b1},
	'{"c.addi16sp zero", 32'h0000_6101, 32'h0000_6101, 1'b1, 1'b1},
	'{"c.srli", 32'h0000_800d, 32'h0034_5413, 1'b1, 1'b0},
	'{"c.srai", 32'h0000_8485, 32'h4014_d493, 1'b1, 1'b0},
	'{"c.srli bit12", 32'h0000_900d, 32'h0000_900d, 1'b1, 1'b1},
	'{"c.andi", 32'h0000_9979, 32'hffe5_7513, 1'b1, 1'b0},
	'{"c.sub", 32'h0000_8c05, 32'h4094_0433, 1'b1, 1'b0},
	'{"c.xor", 32'h0000_8c25, 32'h0094_4433, 1'b1, 1'b0},
	'{"c.or", 32'h0000_8c45, 32'h0094_6433, 1'b1, 1'b0},
	'{"c.and", 32'h0000_8c65, 32'h0094_7433, 1'b1, 1'b0},
	'{"alu reserved", 32'h0000_9c05, 32'h0000_9c05, 1'b1, 1'b1},
	'{"c.beqz", 32'h0000_c401, 32'h0004_0463, 1'b1, 1'b0},
	'{"c.bnez", 32'h0000_fcfd, 32'hfe04_9fe3, 1'b1, 1'b0},
	'{"c.slli", 32'h0000_0292, 32'h0042_9293, 1'b1, 1'b0},
	'{"c.slli bit12", 32'h0000_1292, 32'h0000_1292, 1'b1, 1'b1},
	'{"c.lwsp", 32'h0000_40c2, 32'h0101_2083, 1'b1, 1'b0},
	'{"c.lwsp rd0", 32'h0000_4042, 32'h0000_4042, 1'b1, 1'b1},
	'{"c.mv", 32'h0000_852e, 32'h00b0_0533, 1'b1, 1'b0},
	'{"c.jr", 32'h0000_8082, 32'h0000_8067, 1'b1, 1'b0},
	'{"c.jr rs1 x0", 32'h0000_8002, 32'h0000_8002, 1'b1, 1'b1},
	'{"c.add", 32'h0000_952e, 32'h00b5_0533, 1'b1, 1'b0},
	'{"c.jalr", 32'h0000_9282, 32'h0002_80e7, 1'b1, 1'b0},
	'{"c.ebreak", 32'h0000_9002, 32'h0010_0073, 1'b1, 1'b0},
	'{"c.swsp", 32'h0000_c426, 32'h0091_2423, 1'b1, 1'b0},
	'{"q2 funct3 001", 32'h5a5a_2002, 32'h5a5a_2002, 1'b1, 1'b1},
	'{"addi 32-bit", 32'h00a0_0093, 32'h00a0_0093, 1'b0, 1'b0},
	'{"all ones 32-bit", 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0},
	'{"c.nop high junk", 32'hdead_0001, 32'h0000_0013, 1'b1, 1'b0}
};

`endif

/* tb/tb_rvc_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvc_decoder;

	`include "rvc_tb_vectors.svh"

	localparam int DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int RESET_CYCLES = 3;
	localparam int STALL_AT = 8;
	localparam int STALL_CYCLES = 20;
	localparam int WORST_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + STALL_CYCLES + 20
		+ RVC_NUM_VECTORS * WORST_CYCLES;

	logic clk_i;
	logic arst_n_i;
	logic in_valid_i;
	logic [rvc_pkg::INSTR_W-1:0] in_instr_i;
	logic in_credit_o;
	logic out_valid_o;
	rvc_pkg::rvc_result_t out_result_o;
	logic out_credit_i;

	integer seed = 32'hf544_7c26;
	int checks = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int received = 0;
	int owed = 0;
	int prod_credits = DEPTH;
	int model_count = 0;
	int model_credits = OUT_CREDITS;
	bit stall_done = 1'b0;

	rvc_decoder #(
		.DEPTH      (DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_rvc_decoder (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.in_instr_i  (in_instr_i),
		.in_credit_o (in_credit_o),
		.out_valid_o (out_valid_o),
		.out_result_o(out_result_o),
		.out_credit_i(out_credit_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		protocol_errors++;
		$display("%s at %0t", msg, $time);
	endtask

	function automatic string name_text(input logic [8*16-1:0] packed_name);
		string s;
		s = "";
		for (int i = 15; i >= 0; i--) begin
			if (packed_name[8*i +: 8] != 8'h00) begin
				s = $sformatf("%s%c", s, packed_name[8*i +: 8]);
			end
		end
		return s;
	endfunction

	// outputs settle mid cycle, the negedge view is what the next posedge samples
	always @(negedge clk_i) begin : monitor
		rvc_vec_t vec;
		string nm;
		if (arst_n_i) begin
			if (in_credit_o !== out_valid_o) begin
				report_failure("upstream credit not matched to an item leaving the queue");
			end
			if (in_credit_o && model_count == 0) begin
				report_failure("credit returned with no item sent");
			end
			if (out_valid_o) begin
				if (model_count == 0) begin
					report_failure("output valid with no item sent");
				end else if (model_credits == 0) begin
					report_failure("output valid with no downstream credit");
				end else if (received >= RVC_NUM_VECTORS) begin
					report_failure("more outputs than table rows");
				end else begin
					vec = RVC_VECTORS[received];
					nm = name_text(vec.name);
					check_value({nm, " instr"}, vec.exp_instr, out_result_o.instr);
					check_value({nm, " compressed"}, 32'(vec.exp_compressed),
						32'(out_result_o.is_compressed));
					check_value({nm, " illegal"}, 32'(vec.exp_illegal),
						32'(out_result_o.illegal));
					received++;
					owed++;
				end
			end else if (model_count > 0 && model_credits > 0) begin
				report_failure("item queued and credit held but output not valid");
			end
			if (in_valid_i && model_count == DEPTH) begin
				report_failure("producer wrote into a full queue");
			end
			if (in_credit_o) begin
				prod_credits++;
			end
			model_count = model_count + int'(in_valid_i) - int'(out_valid_o);
			model_credits = model_credits - int'(out_valid_o) + int'(out_credit_i);
		end
	end

	// downstream consumer, random gaps plus one long stall
	initial begin : consumer
		int gap;
		gap = 0;
		out_credit_i = 1'b0;
		wait (arst_n_i === 1'b1);
		forever begin
			@(posedge clk_i);
			#1;
			out_credit_i = 1'b0;
			if (!stall_done && received >= STALL_AT) begin
				repeat (STALL_CYCLES) @(posedge clk_i);
				#1;
				check_value("stall out_valid", 32'd0, 32'(out_valid_o));
				check_value("stall in_credit", 32'd0, 32'(in_credit_o));
				check_value("stall queue level", DEPTH, model_count);
				check_value("stall producer credits", 32'd0, prod_credits);
				stall_done = 1'b1;
			end else if (owed > 0) begin
				if (gap == 0) begin
					out_credit_i = 1'b1;
					owed--;
					gap = $unsigned($random(seed)) % 4;
				end else begin
					gap--;
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_i);
		$display("watchdog expired, %0d of %0d items received", received, RVC_NUM_VECTORS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : driver
		int i;
		arst_n_i = 1'b0;
		in_valid_i = 1'b0;
		in_instr_i = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;

		// idle after reset
		repeat (2) begin
			@(negedge clk_i);
			check_value("reset out_valid", 32'd0, 32'(out_valid_o));
			check_value("reset in_credit", 32'd0, 32'(in_credit_o));
		end

		i = 0;
		while (i < RVC_NUM_VECTORS) begin
			@(posedge clk_i);
			#1;
			if (prod_credits > 0) begin
				in_valid_i = 1'b1;
				in_instr_i = RVC_VECTORS[i].instr;
				prod_credits--;
				i++;
			end else begin
				in_valid_i = 1'b0;
				in_instr_i = '0;
			end
		end
		@(posedge clk_i);
		#1;
		in_valid_i = 1'b0;
		in_instr_i = '0;

		wait (received == RVC_NUM_VECTORS);
		repeat (5) @(posedge clk_i);
		check_value("final queue level", 32'd0, model_count);
		check_value("final output count", RVC_NUM_VECTORS, received);

		$display("checks: %0d, value errors: %0d, protocol errors: %0d",
			checks, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
